//--- sources.f
+incdir+verilog
verilog/aluPkg.sv
verilog/isaPkg.sv
verilog/arithmeticUnit.sv
verilog/logicUnit.sv
verilog/aluOutputStage.sv
verilog/controlUnit.sv
verilog/datapath.sv
verilog/processor8.sv
test/processor8Tb.sv

//--- test/processor8Tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module processor8Tb import isaPkg::*; ();

    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 8;                    // Watched after done

    logic                   clock;
    logic                   reset;
    logic [`DATA_WIDTH-1:0] memReadData;
    logic [`ADDR_WIDTH-1:0] memAddress;
    logic [`DATA_WIDTH-1:0] memWriteData;
    logic                   memRead;
    logic                   memWrite;
    logic                   done;

    logic [`DATA_WIDTH-1:0] mem [0:255];                // External memory model
    logic [`ADDR_WIDTH-1:0] expReadAddr [$];            // Every read in program order
    logic [`ADDR_WIDTH-1:0] expWriteAddr [$];
    logic [`DATA_WIDTH-1:0] expWriteData [$];
    logic [`ADDR_WIDTH-1:0] wantAddr;
    logic [`DATA_WIDTH-1:0] wantData;
    logic [`ADDR_WIDTH-1:0] loadPtr;                    // Next program byte
    logic [`ADDR_WIDTH-1:0] answerPtr;                  // Next expected answer slot
    logic [31:0]            lcgState;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    int                     cycleBudget;                // Summed per-instruction cycles
    int                     cycleCount;
    int                     cycleLimit;
    int                     checkCount;
    int                     errorCount;

    processor8 processor8_inst (
        .clock(clock), .reset(reset), .memReadData(memReadData),
        .memAddress(memAddress), .memWriteData(memWriteData),
        .memRead(memRead), .memWrite(memWrite), .done(done)
    );

    always #20 clock = ~clock;                          // 40 ns period

    // Memory answers on the falling edge and holds data until the next read
    always @(negedge clock) begin
        if (memRead) begin
            checkCount++;
            if (expReadAddr.size() == 0) begin
                errorCount++;
                $display("Unexpected read from address %02h at %0t", memAddress, $time);
            end else begin
                wantAddr = expReadAddr.pop_front();
                assert (memAddress == wantAddr) else begin
                    errorCount++;
                    $display("CHECK FAILED at %0t: read address %02h, expected %02h",
                             $time, memAddress, wantAddr);
                end
            end
            memReadData <= mem[memAddress];
        end
        if (memWrite) begin
            checkCount++;
            if (expWriteAddr.size() == 0) begin
                errorCount++;
                $display("Unexpected write of %02h to address %02h at %0t",
                         memWriteData, memAddress, $time);
            end else begin
                wantAddr = expWriteAddr.pop_front();
                wantData = expWriteData.pop_front();
                assert (memAddress == wantAddr && memWriteData == wantData) else begin
                    errorCount++;
                    $display("CHECK FAILED at %0t: write %02h to %02h, expected %02h to %02h",
                             $time, memWriteData, memAddress, wantData, wantAddr);
                end
            end
            mem[memAddress] = memWriteData;
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: done never rose within %0d cycles", cycleLimit);
            $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    function logic [`DATA_WIDTH-1:0] nextRandomByte();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[23:16];
    endfunction

    // Result in the high byte, flags word in the low byte
    function automatic logic [15:0] aluModel(input logic [7:0] opc, input logic [7:0] x,
                                             input logic [7:0] y);
        logic [8:0]  wide;
        logic [15:0] prod;
        logic [7:0]  r;
        logic        hasSign;
        logic        c;
        logic        v;
        logic        g;
        logic        l;
        logic        z;
        int          signedSum;
        r       = '0;
        c       = 1'b0;
        v       = 1'b0;
        g       = 1'b0;
        l       = 1'b0;
        hasSign = 1'b1;
        case (opc)
            8'h01: begin
                wide = {1'b0, x} + 9'd1;
                r    = wide[7:0];
                c    = wide[8];
                v    = (x == 8'h7F);
            end
            8'h02: begin
                r = x - 8'd1;
                c = (x == 8'h00);                       // Borrow out of zero
                v = (x == 8'h80);
            end
            8'h03: r = ~x;
            8'h10: begin
                wide      = {1'b0, x} + {1'b0, y};
                r         = wide[7:0];
                c         = wide[8];
                signedSum = $signed(x) + $signed(y);
                v         = (signedSum > 127) || (signedSum < -128);
            end
            8'h20: begin
                r         = x - y;
                c         = (x < y);
                signedSum = $signed(x) - $signed(y);
                v         = (signedSum > 127) || (signedSum < -128);
            end
            8'h30: begin
                prod    = {8'h00, x} * {8'h00, y};
                r       = prod[7:0];
                v       = (prod[15:8] != 8'h00);
                hasSign = 1'b0;
            end
            8'h40, 8'h50: begin
                if (y == 8'h00)
                    return {`DIV_ERROR, 1'b0, {`FLAG_WIDTH{1'b1}}};
                r       = (opc == 8'h40) ? x / y : x % y;
                hasSign = 1'b0;
            end
            8'hC0: begin
                g       = (x > y);
                l       = (x < y);
                hasSign = 1'b0;
            end
            8'h60: r = x & y;
            8'h70: r = x | y;
            8'h80: r = x ^ y;
            8'h90: r = ~(x & y);
            8'hA0: r = ~(x | y);
            8'hB0: r = ~(x ^ y);
            default: ;
        endcase
        z = (opc == 8'hC0) ? (x == y) : (r == 8'h00);
        return {r, 1'b0, hasSign & r[7], c, z, ^r, v, g, l};
    endfunction

    task automatic expectWrite(input logic [7:0] data);
        expWriteAddr.push_back(answerPtr);
        expWriteData.push_back(data);
        answerPtr++;
    endtask

    task automatic expectRecord(input logic [7:0] opc, input logic [7:0] x,
                                input logic [7:0] y);
        logic [15:0] model;
        model = aluModel(opc, x, y);
        expectWrite(opc);
        expectWrite(model[15:8]);
        expectWrite(model[7:0]);
    endtask

    task automatic placeByte(input logic [7:0] data);
        mem[loadPtr] = data;
        expReadAddr.push_back(loadPtr);
        loadPtr++;
    endtask

    task automatic addBinary(input logic [7:0] opc, input logic [7:0] x, input logic [7:0] y);
        placeByte(opc);
        placeByte(x);
        placeByte(y);
        expectRecord(opc, x, y);
        cycleBudget += 10;
    endtask

    task automatic addUnary(input logic [7:0] opc, input logic [7:0] x);
        placeByte(opc);
        placeByte(x);
        expectRecord(opc, x, 8'h00);
        cycleBudget += 8;
    endtask

    // Skipped bytes hold an add opcode so a stray fetch breaks the read order
    task automatic addJump(input logic [7:0] distance);
        placeByte(OP_JUMP);
        placeByte(distance);
        for (int i = 0; i < distance; i++)
            mem[loadPtr + i] = 8'h10;
        loadPtr = loadPtr + distance;
        expectWrite(OP_JUMP);
        expectWrite(distance);
        cycleBudget += 7;
    endtask

    task automatic addHalt(input logic [7:0] opc);
        placeByte(opc);
        cycleBudget += 3;
    endtask

    task automatic beginProgram();
        if (reset)
            @(negedge clock);                           // Reassert between programs
        reset = 1'b0;
        expReadAddr.delete();
        expWriteAddr.delete();
        expWriteData.delete();
        for (int i = 0; i < 256; i++)
            mem[i] = i[7:0] ^ 8'hA5;
        loadPtr     = '0;
        answerPtr   = `ANSWER_BASE;
        cycleBudget = 0;
    endtask

    task automatic checkQuiet(input logic wantDone);
        checkCount++;
        assert (!memRead && !memWrite && done == wantDone) else begin
            errorCount++;
            $display("CHECK FAILED at %0t: memRead %b memWrite %b done %b while idle",
                     $time, memRead, memWrite, done);
        end
    endtask

    task automatic runProgram();
        cycleLimit = cycleCount + 2 * cycleBudget + RESET_CYCLES + IDLE_CYCLES;
        repeat (RESET_CYCLES) begin
            @(negedge clock);
            checkQuiet(1'b0);
        end
        reset = 1'b1;
        while (!done)
            @(negedge clock);
        checkCount++;
        assert (expReadAddr.size() == 0 && expWriteAddr.size() == 0) else begin
            errorCount++;
            $display("Halted early with %0d reads and %0d writes still expected",
                     expReadAddr.size(), expWriteAddr.size());
        end
        repeat (IDLE_CYCLES) begin
            @(negedge clock);
            checkQuiet(1'b1);
        end
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b0;
        memReadData = '0;
        cycleCount  = 0;
        cycleLimit  = 1000;
        checkCount  = 0;
        errorCount  = 0;
        lcgState    = 32'h9c2d6163;

        // Every opcode once with random operands then a plain halt
        beginProgram();
        for (int i = 1; i <= 12; i++) begin
            a = nextRandomByte();
            b = nextRandomByte();
            addBinary({i[3:0], 4'h0}, a, b);
        end
        addUnary(OP_INC, nextRandomByte());
        addUnary(OP_DEC, nextRandomByte());
        addUnary(OP_NOT, nextRandomByte());
        addJump(8'd3);
        addBinary(8'h40, nextRandomByte(), 8'h00);      // Divide by zero
        addBinary(8'h50, nextRandomByte(), 8'h00);
        addHalt(OP_HALT);
        runProgram();

        // Flag corner cases then an unknown opcode
        beginProgram();
        addUnary(OP_INC, 8'hFF);
        addUnary(OP_DEC, 8'h80);
        addBinary(8'h10, 8'h7F, 8'h01);
        addBinary(8'h20, 8'h00, 8'h01);
        addBinary(8'hC0, 8'h5A, 8'h5A);
        addBinary(8'h30, 8'h10, 8'h10);
        addHalt(8'hD0);
        runProgram();

        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verilog/aluOutputStage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module aluOutputStage import aluPkg::*; (
    input  aluOp                   op,
    input  logic [`DATA_WIDTH-1:0] arithResult,
    input  logic [`DATA_WIDTH-1:0] logicResult,
    input  logic                   carry,
    input  logic                   overflow,
    input  logic                   greater,
    input  logic                   less,
    input  logic                   divByZero,
    output logic [`DATA_WIDTH-1:0] aluResult,
    output aluFlags                flags
);

    logic isLogic;

    always_comb begin
        isLogic = op inside {ALU_AND, ALU_OR, ALU_NOTA, ALU_XOR, ALU_NAND, ALU_NOR, ALU_XNOR};

        if (isLogic)
            aluResult = logicResult;
        else if (op == ALU_CMP)
            aluResult = '0;                                 // Compare has no result
        else
            aluResult = arithResult;

        flags          = '0;
        flags.zero     = (aluResult == '0);
        flags.parity   = ^aluResult;
        flags.carry    = carry;                             // Zero unless add or subtract
        flags.overflow = overflow;                          // Add, subtract, multiply
        if (isLogic || op == ALU_ADD || op == ALU_SUB)
            flags.sign = aluResult[`DATA_WIDTH-1];
        if (op == ALU_CMP) begin
            flags.zero    = !greater && !less;              // A equals B
            flags.greater = greater;
            flags.less    = less;
        end

        // Divide by zero overrides everything
        if (divByZero) begin
            aluResult = `DIV_ERROR;
            flags     = aluFlags'({`FLAG_WIDTH{1'b1}});
        end
    end

endmodule

//--- verilog/aluPkg.sv
package aluPkg;

    // Operation select, shared by all ALU units
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_MUL  = 4'h2,
        ALU_DIV  = 4'h3,
        ALU_MOD  = 4'h4,
        ALU_CMP  = 4'h5,
        ALU_AND  = 4'h6,
        ALU_OR   = 4'h7,
        ALU_NOTA = 4'h8,
        ALU_XOR  = 4'hA,
        ALU_NAND = 4'hB,
        ALU_NOR  = 4'hC,
        ALU_XNOR = 4'hD
    } aluOp;

    // Flags word, top bit first
    typedef struct packed {
        logic sign;
        logic carry;        // Carry out, or borrow on subtract
        logic zero;
        logic parity;       // XOR of result bits
        logic overflow;
        logic greater;      // Compare only
        logic less;         // Compare only
    } aluFlags;

endpackage

//--- verilog/arithmeticUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module arithmeticUnit import aluPkg::*; (
    input  logic [`DATA_WIDTH-1:0] operandA,
    input  logic [`DATA_WIDTH-1:0] operandB,
    input  aluOp                   op,
    output logic [`DATA_WIDTH-1:0] arithResult,
    output logic                   carry,
    output logic                   overflow,
    output logic                   greater,
    output logic                   less,
    output logic                   divByZero
);

    logic [`DATA_WIDTH:0]     sum;          // Extra bit holds carry out
    logic [`DATA_WIDTH-1:0]   diff;
    logic [2*`DATA_WIDTH-1:0] product;      // Full product, upper byte for overflow
    logic [`DATA_WIDTH-1:0]   quotient;
    logic [`DATA_WIDTH-1:0]   remainder;
    logic                     bIsZero;
    logic                     signA;
    logic                     signB;

    always_comb begin
        signA     = operandA[`DATA_WIDTH-1];
        signB     = operandB[`DATA_WIDTH-1];
        bIsZero   = (operandB == '0);
        sum       = {1'b0, operandA} + {1'b0, operandB};
        diff      = operandA - operandB;
        product   = operandA * operandB;
        quotient  = bIsZero ? '0 : operandA / operandB;     // Keep X out of the divider
        remainder = bIsZero ? '0 : operandA % operandB;

        arithResult = '0;
        carry       = 1'b0;
        overflow    = 1'b0;
        greater     = 1'b0;
        less        = 1'b0;
        divByZero   = 1'b0;

        case (op)
            ALU_ADD: begin
                arithResult = sum[`DATA_WIDTH-1:0];
                carry       = sum[`DATA_WIDTH];
                overflow    = (signA == signB) && (sum[`DATA_WIDTH-1] != signA);
            end
            ALU_SUB: begin
                arithResult = diff;
                carry       = (operandA < operandB);        // Unsigned borrow
                overflow    = (signA != signB) && (diff[`DATA_WIDTH-1] != signA);
            end
            ALU_MUL: begin
                arithResult = product[`DATA_WIDTH-1:0];
                overflow    = |product[2*`DATA_WIDTH-1:`DATA_WIDTH];
            end
            ALU_DIV: begin
                arithResult = quotient;
                divByZero   = bIsZero;
            end
            ALU_MOD: begin
                arithResult = remainder;
                divByZero   = bIsZero;
            end
            ALU_CMP: begin
                greater = (operandA > operandB);            // Unsigned compare
                less    = (operandA < operandB);
            end
            default: ;                                      // Logic ops handled elsewhere
        endcase
    end

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import isaPkg::*, aluPkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  instrWord        instr,          // From instruction register
    output logic            irLoad,
    output logic            aLoad,
    output logic            bLoad,
    output logic            resultLoad,     // Capture ALU result and flags
    output logic            pcInc,
    output logic            pcJump,
    output logic            answerInc,
    output logic            memRead,
    output logic            memWrite,
    output logic            done,
    output isaPkg::addrSel  addrSel,
    output isaPkg::writeSel writeSel,
    output isaPkg::bSel     bSel,
    output aluOp            op
);

    typedef enum logic [3:0] {
        S_START, S_FETCH, S_CAPTURE, S_DECODE, S_ACAP, S_BREAD, S_BCAP,
        S_EXEC, S_WROP, S_WRRES, S_WRFLAG, S_WRDIST, S_HALT
    } stateT;

    stateT state;
    stateT next;
    logic  isJump;
    logic  isIncDec;
    logic  isUnary;
    logic  isBinary;
    logic  isHalt;

    // Raw view for halt, unary, jump; nibble view for binary ops
    always_comb begin
        isJump   = (instr.raw == OP_JUMP);
        isIncDec = (instr.raw == OP_INC) || (instr.raw == OP_DEC);
        isUnary  = isIncDec || (instr.raw == OP_NOT);
        isBinary = 1'b0;
        op       = ALU_ADD;                     // Also inc
        if (instr.raw == OP_DEC)
            op = ALU_SUB;
        else if (instr.raw == OP_NOT)
            op = ALU_NOTA;
        if (instr.nib.unOp == 4'h0) begin
            isBinary = 1'b1;
            case (instr.nib.binOp)
                NIB_ADD:  op = ALU_ADD;
                NIB_SUB:  op = ALU_SUB;
                NIB_MUL:  op = ALU_MUL;
                NIB_DIV:  op = ALU_DIV;
                NIB_MOD:  op = ALU_MOD;
                NIB_AND:  op = ALU_AND;
                NIB_OR:   op = ALU_OR;
                NIB_XOR:  op = ALU_XOR;
                NIB_NAND: op = ALU_NAND;
                NIB_NOR:  op = ALU_NOR;
                NIB_XNOR: op = ALU_XNOR;
                NIB_CMP:  op = ALU_CMP;
                default:  isBinary = 1'b0;      // OP_HALT lands here too
            endcase
        end
        isHalt = !(isUnary || isJump || isBinary);  // Unknown codes halt
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            state <= S_START;
        else
            state <= next;
    end

    always_comb begin
        next       = state;
        irLoad     = 1'b0;
        aLoad      = 1'b0;
        bLoad      = 1'b0;
        resultLoad = 1'b0;
        pcInc      = 1'b0;
        pcJump     = 1'b0;
        answerInc  = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        done       = 1'b0;
        addrSel    = ADDR_PC;
        writeSel   = WR_OPCODE;
        bSel       = B_MEMORY;
        case (state)
            S_START: next = S_FETCH;                // Keeps strobes low out of reset
            S_FETCH: begin
                memRead = 1'b1;
                pcInc   = 1'b1;
                next    = S_CAPTURE;
            end
            S_CAPTURE: begin
                irLoad = 1'b1;
                next   = S_DECODE;
            end
            S_DECODE: begin                         // Decode overlaps first operand read
                if (isHalt) begin
                    next = S_HALT;
                end else begin
                    memRead = 1'b1;
                    pcInc   = 1'b1;
                    next    = isJump ? S_BCAP : S_ACAP;
                    if (isIncDec) begin             // Immediate 1 into B
                        bLoad = 1'b1;
                        bSel  = B_ONE;
                    end
                end
            end
            S_ACAP: begin
                aLoad = 1'b1;
                next  = isBinary ? S_BREAD : S_EXEC;
            end
            S_BREAD: begin
                memRead = 1'b1;
                pcInc   = 1'b1;
                next    = S_BCAP;
            end
            S_BCAP: begin                           // Operand B or jump distance
                bLoad = 1'b1;
                next  = S_EXEC;
            end
            S_EXEC: begin
                pcJump     = isJump;
                resultLoad = !isJump;
                next       = S_WROP;
            end
            S_WROP: begin
                memWrite  = 1'b1;
                answerInc = 1'b1;
                addrSel   = ADDR_ANSWER;
                next      = isJump ? S_WRDIST : S_WRRES;
            end
            S_WRRES: begin
                memWrite  = 1'b1;
                answerInc = 1'b1;
                addrSel   = ADDR_ANSWER;
                writeSel  = WR_RESULT;
                next      = S_WRFLAG;
            end
            S_WRFLAG: begin
                memWrite  = 1'b1;
                answerInc = 1'b1;
                addrSel   = ADDR_ANSWER;
                writeSel  = WR_FLAGS;
                next      = S_FETCH;
            end
            S_WRDIST: begin
                memWrite  = 1'b1;
                answerInc = 1'b1;
                addrSel   = ADDR_ANSWER;
                writeSel  = WR_OPERAND_B;
                next      = S_FETCH;
            end
            S_HALT: done = 1'b1;                    // Frozen until reset
            default: next = S_START;
        endcase
    end

endmodule

//--- verilog/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Word and address widths
`define DATA_WIDTH 8
`define ADDR_WIDTH 8

// First answer slot, also answer pointer reset value
`define ANSWER_BASE 8'h80

// Flags word is sign, carry, zero, parity, overflow, greater, less
`define FLAG_WIDTH 7

// Result reported on divide by zero
`define DIV_ERROR 8'hFF

`endif

//--- verilog/datapath.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath import isaPkg::*, aluPkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   irLoad,
    input  logic                   aLoad,
    input  logic                   bLoad,
    input  logic                   resultLoad,
    input  logic                   pcInc,
    input  logic                   pcJump,
    input  logic                   answerInc,
    input  isaPkg::addrSel         addrSel,
    input  isaPkg::writeSel        writeSel,
    input  isaPkg::bSel            bSel,
    input  logic [`DATA_WIDTH-1:0] memReadData,
    input  logic [`DATA_WIDTH-1:0] aluResult,
    input  aluFlags                flags,
    output instrWord               instr,
    output logic [`DATA_WIDTH-1:0] operandA,
    output logic [`DATA_WIDTH-1:0] operandB,
    output logic [`ADDR_WIDTH-1:0] memAddress,
    output logic [`DATA_WIDTH-1:0] memWriteData
);

    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ADDR_WIDTH-1:0] answerPtr;      // Next answer slot
    logic [`DATA_WIDTH-1:0] resultReg;
    aluFlags                flagsReg;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc        <= '0;
            answerPtr <= `ANSWER_BASE;
            instr     <= OP_HALT;
        end else begin
            if (pcJump)
                pc <= pc + operandB;        // PC already past the distance byte
            else if (pcInc)
                pc <= pc + 1'b1;
            if (answerInc)
                answerPtr <= answerPtr + 1'b1;
            if (irLoad)
                instr <= memReadData;
        end
    end

    // Operands and result record
    always_ff @(posedge clock) begin
        if (aLoad)
            operandA <= memReadData;
        if (bLoad)
            operandB <= (bSel == B_ONE) ? `DATA_WIDTH'(1) : memReadData;
        if (resultLoad) begin
            resultReg <= aluResult;
            flagsReg  <= flags;
        end
    end

    assign memAddress = (addrSel == ADDR_ANSWER) ? answerPtr : pc;

    always_comb begin
        case (writeSel)
            WR_OPCODE:  memWriteData = instr.raw;
            WR_RESULT:  memWriteData = resultReg;
            WR_FLAGS:   memWriteData = {{(`DATA_WIDTH-`FLAG_WIDTH){1'b0}}, flagsReg};
            default:    memWriteData = operandB;    // Jump distance
        endcase
    end

endmodule

//--- verilog/isaPkg.sv
`include "cpu_macros.svh"

package isaPkg;

    // Full-byte opcodes
    localparam logic [`DATA_WIDTH-1:0] OP_HALT = 8'h00;
    localparam logic [`DATA_WIDTH-1:0] OP_INC  = 8'h01;
    localparam logic [`DATA_WIDTH-1:0] OP_DEC  = 8'h02;
    localparam logic [`DATA_WIDTH-1:0] OP_NOT  = 8'h03;
    localparam logic [`DATA_WIDTH-1:0] OP_JUMP = 8'h04;

    // Binary ops live in the high nibble, low nibble zero
    localparam logic [3:0] NIB_ADD  = 4'h1;
    localparam logic [3:0] NIB_SUB  = 4'h2;
    localparam logic [3:0] NIB_MUL  = 4'h3;
    localparam logic [3:0] NIB_DIV  = 4'h4;
    localparam logic [3:0] NIB_MOD  = 4'h5;
    localparam logic [3:0] NIB_AND  = 4'h6;
    localparam logic [3:0] NIB_OR   = 4'h7;
    localparam logic [3:0] NIB_XOR  = 4'h8;
    localparam logic [3:0] NIB_NAND = 4'h9;
    localparam logic [3:0] NIB_NOR  = 4'hA;
    localparam logic [3:0] NIB_XNOR = 4'hB;
    localparam logic [3:0] NIB_CMP  = 4'hC;

    // Same byte seen whole or as two nibbles
    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;    // Halt, unary and jump compare
        struct packed {
            logic [3:0] binOp;          // Binary op code
            logic [3:0] unOp;           // Unary code
        } nib;
    } instrWord;

    typedef enum logic {ADDR_PC, ADDR_ANSWER} addrSel;
    typedef enum logic [1:0] {WR_OPCODE, WR_RESULT, WR_FLAGS, WR_OPERAND_B} writeSel;
    typedef enum logic {B_MEMORY, B_ONE} bSel;     // B_ONE for inc and dec

endpackage

//--- verilog/logicUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module logicUnit import aluPkg::*; (
    input  logic [`DATA_WIDTH-1:0] operandA,
    input  logic [`DATA_WIDTH-1:0] operandB,
    input  aluOp                   op,
    output logic [`DATA_WIDTH-1:0] logicResult
);

    always_comb begin
        case (op)
            ALU_AND:  logicResult = operandA & operandB;
            ALU_OR:   logicResult = operandA | operandB;
            ALU_XOR:  logicResult = operandA ^ operandB;
            ALU_NAND: logicResult = ~(operandA & operandB);
            ALU_NOR:  logicResult = ~(operandA | operandB);
            ALU_XNOR: logicResult = ~(operandA ^ operandB);
            ALU_NOTA: logicResult = ~operandA;              // NOT opcode, B ignored
            default:  logicResult = '0;                     // Arithmetic ops
        endcase
    end

endmodule

//--- verilog/processor8.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module processor8 import isaPkg::*, aluPkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`DATA_WIDTH-1:0] memReadData,     // Valid the cycle after memRead
    output logic [`ADDR_WIDTH-1:0] memAddress,
    output logic [`DATA_WIDTH-1:0] memWriteData,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   done
);

    logic                   irLoad;
    logic                   aLoad;
    logic                   bLoad;
    logic                   resultLoad;
    logic                   pcInc;
    logic                   pcJump;
    logic                   answerInc;
    isaPkg::addrSel         addrSel;
    isaPkg::writeSel        writeSel;
    isaPkg::bSel            bSel;
    aluOp                   op;
    instrWord               instr;
    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] arithResult;
    logic [`DATA_WIDTH-1:0] logicResult;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   carry;
    logic                   overflow;
    logic                   greater;
    logic                   less;
    logic                   divByZero;
    aluFlags                flags;

    controlUnit controlUnit_inst (
        .clock(clock), .reset(reset), .instr(instr),
        .irLoad(irLoad), .aLoad(aLoad), .bLoad(bLoad), .resultLoad(resultLoad),
        .pcInc(pcInc), .pcJump(pcJump), .answerInc(answerInc),
        .memRead(memRead), .memWrite(memWrite), .done(done),
        .addrSel(addrSel), .writeSel(writeSel), .bSel(bSel), .op(op)
    );

    datapath datapath_inst (
        .clock(clock), .reset(reset),
        .irLoad(irLoad), .aLoad(aLoad), .bLoad(bLoad), .resultLoad(resultLoad),
        .pcInc(pcInc), .pcJump(pcJump), .answerInc(answerInc),
        .addrSel(addrSel), .writeSel(writeSel), .bSel(bSel),
        .memReadData(memReadData), .aluResult(aluResult), .flags(flags),
        .instr(instr), .operandA(operandA), .operandB(operandB),
        .memAddress(memAddress), .memWriteData(memWriteData)
    );

    // Arithmetic and logic side by side, merged in the output stage
    arithmeticUnit arithmeticUnit_inst (
        .operandA(operandA), .operandB(operandB), .op(op),
        .arithResult(arithResult), .carry(carry), .overflow(overflow),
        .greater(greater), .less(less), .divByZero(divByZero)
    );

    logicUnit logicUnit_inst (
        .operandA(operandA), .operandB(operandB), .op(op),
        .logicResult(logicResult)
    );

    aluOutputStage aluOutputStage_inst (
        .op(op), .arithResult(arithResult), .logicResult(logicResult),
        .carry(carry), .overflow(overflow), .greater(greater), .less(less),
        .divByZero(divByZero), .aluResult(aluResult), .flags(flags)
    );

endmodule
